// File: verilog/uart_pkg.sv
package uart_pkg;

    // 8N1 framing
    localparam int DATA_BITS = 8;

    localparam logic IDLE_LEVEL  = 1'b1; // line level between frames and in the stop bit
    localparam logic START_LEVEL = 1'b0;

    // one received byte, valid is a single-cycle strobe
    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
    } rx_byte_t;

endpackage

// File: verilog/sram_pkg.sv
package sram_pkg;

    localparam int SRAM_AW = 20; // word address, same as base_ram_addr on the board
    localparam int LANES   = 4;
    localparam int LANE_W  = 8;

    // one data word, either whole on the bus or split into byte lanes
    typedef union packed {
        logic [LANES*LANE_W-1:0]     word;
        logic [LANES-1:0][LANE_W-1:0] lanes; // lanes[0] is bits 7:0
    } sram_word_u;

    // strobes are all active low
    typedef struct packed {
        logic [SRAM_AW-1:0] addr;
        sram_word_u         wdata;
        logic [LANES-1:0]   be_n;
        logic               ce_n;
        logic               we_n;
    } sram_req_t;

    // byte enables with only the selected lane low
    function automatic logic [LANES-1:0] lane_be_n(input logic [$clog2(LANES)-1:0] lane);
        logic [LANES-1:0] one_hot;
        one_hot = LANES'(1) << lane;
        return ~one_hot;
    endfunction

endpackage

// File: verilog/uart_rx.sv
module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rxd,
    output rx_byte_t rx,
    output logic     frame_err
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(DATA_BITS - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t               state_q;
    logic [2:0]           sync_q;   // two sync stages plus one for edge detect
    logic                 rxd_s;
    logic                 rxd_fall;
    logic                 tick;
    logic [CNT_W-1:0]     cnt_q;
    logic [IDX_W-1:0]     idx_q;
    logic [DATA_BITS-1:0] shift_q;
    logic [DATA_BITS-1:0] data_q;
    logic                 valid_q;

    assign rxd_s    = sync_q[1];
    assign rxd_fall = (sync_q[2] == IDLE_LEVEL) && (sync_q[1] == START_LEVEL);

    // mid-period of the start bit, then one full period per following bit
    assign tick = (state_q == START) ? (cnt_q == HALF_LAST) : (cnt_q == BIT_LAST);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= {3{IDLE_LEVEL}};
        end else begin
            sync_q <= {sync_q[1:0], rxd};
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            idx_q     <= '0;
            valid_q   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (state_q == IDLE || tick) cnt_q <= '0;
            else cnt_q <= cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    if (rxd_fall) state_q <= START;
                end
                START: begin
                    if (tick) begin
                        idx_q   <= '0;
                        state_q <= (rxd_s == START_LEVEL) ? DATA : IDLE; // glitch goes back
                    end
                end
                DATA: begin
                    if (tick) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == IDX_LAST) state_q <= STOP;
                    end
                end
                STOP: begin
                    if (tick) begin
                        state_q <= IDLE;
                        if (rxd_s == IDLE_LEVEL) valid_q <= 1'b1;
                        else frame_err <= 1'b1; // sticky
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state_q == DATA && tick) shift_q <= {rxd_s, shift_q[DATA_BITS-1:1]}; // lsb first
        if (state_q == STOP && tick) data_q <= shift_q;
    end

    assign rx.valid = valid_q;
    assign rx.data  = data_q;

endmodule

// File: verilog/byte_fifo.sv
module byte_fifo import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  rx_byte_t             wr,
    input  logic                 pop,
    output logic [DATA_BITS-1:0] rd_data,
    output logic                 empty,
    output logic                 overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
    logic [AW:0]          wr_ptr_q;   // extra msb tells full from empty
    logic [AW:0]          rd_ptr_q;
    logic                 full;
    logic                 do_write;
    logic                 do_read;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW])
                && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign do_write = wr.valid && !full;
    assign do_read  = pop && !empty;

    // show-ahead, head byte is always on the output
    assign rd_data = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_read) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (wr.valid && full) begin
                overflow <= 1'b1; // byte is lost, flag stays until reset
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_write) begin
            mem[wr_ptr_q[AW-1:0]] <= wr.data;
        end
    end

endmodule

// File: verilog/sram_loader.sv
module sram_loader import sram_pkg::*; #(
    parameter logic [SRAM_AW-1:0] BASE_ADDR = '0
) (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              load_en,
    input  logic [LANE_W-1:0] rd_data,
    input  logic              empty,
    output logic              pop,
    output sram_req_t         sram,
    output logic [31:0]       byte_count
);

    localparam int LANE_IDX_W = $clog2(LANES);
    localparam int PTR_W      = SRAM_AW + LANE_IDX_W;

    typedef enum logic [1:0] {IDLE, WRITE, RECOVER} state_t;

    state_t                  state_q;
    logic [31:0]             count_q;
    logic [PTR_W-1:0]        byte_ptr;
    logic [LANE_IDX_W-1:0]   lane;
    logic [SRAM_AW-1:0]      word_addr;
    sram_word_u              wdata_d;
    sram_word_u              wdata_q;
    logic [SRAM_AW-1:0]      addr_q;
    logic [LANES-1:0]        be_n_q;
    logic                    ce_n_q;
    logic                    we_n_q;

    // bytes written so far double as the byte pointer
    assign byte_ptr  = count_q[PTR_W-1:0];
    assign lane      = byte_ptr[LANE_IDX_W-1:0];
    assign word_addr = BASE_ADDR + byte_ptr[PTR_W-1:LANE_IDX_W];

    assign pop = (state_q == IDLE) && load_en && !empty;

    // byte on its own lane, the other lanes zero
    always_comb begin
        wdata_d.lanes       = '0;
        wdata_d.lanes[lane] = rd_data;
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            count_q <= '0;
            be_n_q  <= '1;
            ce_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (pop) begin
                        state_q <= WRITE;
                        ce_n_q  <= 1'b0;
                        we_n_q  <= 1'b0;
                        be_n_q  <= lane_be_n(lane);
                    end
                end
                WRITE: begin    // single write cycle on the bus
                    state_q <= RECOVER;
                    ce_n_q  <= 1'b1;
                    we_n_q  <= 1'b1;
                    be_n_q  <= '1;
                    count_q <= count_q + 1'b1;
                end
                RECOVER: begin
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // address and data are captured with the popped byte
    always_ff @(posedge clk_in) begin
        if (pop) begin
            addr_q  <= word_addr;
            wdata_q <= wdata_d;
        end
    end

    assign sram.addr       = addr_q;
    assign sram.wdata.word = wdata_q.word;
    assign sram.be_n       = be_n_q;
    assign sram.ce_n       = ce_n_q;
    assign sram.we_n       = we_n_q;

    assign byte_count = count_q;

endmodule

// File: verilog/uart_loader_top.sv
module uart_loader_top import uart_pkg::*, sram_pkg::*; #(
    parameter int                 CLKS_PER_BIT = 434, // 50 MHz, 115200 baud
    parameter int                 FIFO_DEPTH   = 16,
    parameter logic [SRAM_AW-1:0] BASE_ADDR    = '0
) (
    input  logic        clk_in,
    input  logic        arst_n,
    input  logic        rxd,
    input  logic        load_en,
    output sram_req_t   sram,
    output logic        frame_err,
    output logic        overflow,
    output logic [31:0] byte_count
);

    rx_byte_t             rx;
    logic [DATA_BITS-1:0] fifo_data;
    logic                 fifo_empty;
    logic                 fifo_pop;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx_inst (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .rxd       (rxd),
        .rx        (rx),
        .frame_err (frame_err)
    );

    // no back-pressure towards the receiver, full drops the byte
    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) byte_fifo_inst (
        .clk_in   (clk_in),
        .arst_n   (arst_n),
        .wr       (rx),
        .pop      (fifo_pop),
        .rd_data  (fifo_data),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    sram_loader #(
        .BASE_ADDR (BASE_ADDR)
    ) sram_loader_inst (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .load_en    (load_en),
        .rd_data    (fifo_data),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .sram       (sram),
        .byte_count (byte_count)
    );

endmodule

// File: tests/uart_loader_asserts.sv
module uart_loader_asserts import sram_pkg::*; (
    input logic        clk_in,
    input logic        arst_n,
    input sram_req_t   sram,
    input logic        pop,
    input logic [31:0] byte_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // read by the testbench at the end

    // write strobe is a single cycle
    we_single: assert property (@(posedge clk_in) disable iff (!arst_n)
        !sram.we_n |=> sram.we_n)
        else begin
            $error("we_n held low for more than one cycle");
            fail_count++;
        end

    be_one_lane: assert property (@(posedge clk_in) disable iff (!arst_n)
        !sram.we_n |-> $onehot(~sram.be_n))
        else begin
            $error("write with be_n %b, expected exactly one lane low", sram.be_n);
            fail_count++;
        end

    // each popped byte goes out in the very next cycle
    pop_write: assert property (@(posedge clk_in) disable iff (!arst_n)
        pop |=> !sram.ce_n && !sram.we_n)
        else begin
            $error("pop was not followed by a write cycle");
            fail_count++;
        end

    count_up: assert property (@(posedge clk_in) disable iff (!arst_n)
        byte_count >= $past(byte_count))
        else begin
            $error("byte_count went down to %0d", byte_count);
            fail_count++;
        end

endmodule

bind uart_loader_top uart_loader_asserts uart_loader_asserts_inst (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .sram       (sram),
    .pop        (fifo_pop),
    .byte_count (byte_count)
);

// File: tests/tb_uart_loader.sv
module tb_uart_loader import sram_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                 CLKS_PER_BIT  = 8;
    localparam int                 FIFO_DEPTH    = 4;
    localparam logic [SRAM_AW-1:0] BASE_ADDR     = 20'h100;
    localparam int                 DRAIN_TIMEOUT = 400; // cycles

    logic        clk_in;
    logic        arst_n;
    logic        rxd;
    logic        load_en;
    sram_req_t   sram;
    logic        frame_err;
    logic        overflow;
    logic [31:0] byte_count;

    integer      seed = 32'h0a72cd77;
    int          errors = 0;
    int          checks = 0;
    int          write_count = 0;
    int          fifo_level = 0; // modelled FIFO occupancy
    int          dropped = 0;
    logic        load_on = 1'b0;
    logic [7:0]  expected_bytes [$];
    logic [31:0] sram_mem [logic [SRAM_AW-1:0]];

    uart_loader_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .BASE_ADDR    (BASE_ADDR)
    ) uart_loader_top_inst (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .rxd        (rxd),
        .load_en    (load_en),
        .sram       (sram),
        .frame_err  (frame_err),
        .overflow   (overflow),
        .byte_count (byte_count)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // asynchronous SRAM, only lanes with be_n low take the data
    always @(posedge clk_in) begin
        logic [31:0] word;
        if (arst_n && !sram.ce_n && !sram.we_n) begin
            word = sram_mem.exists(sram.addr) ? sram_mem[sram.addr] : 32'h0;
            for (int l = 0; l < 4; l++) begin
                if (!sram.be_n[l]) word[l*8 +: 8] = sram.wdata.lanes[l];
            end
            sram_mem[sram.addr] = word;
            write_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_bit(input logic level);
        @(posedge clk_in);
        rxd <= level;
        repeat (CLKS_PER_BIT - 1) @(posedge clk_in);
    endtask

    // start, 8 data bits lsb first, stop, then one idle bit time
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);
    endtask

    task automatic model_frame(input logic [7:0] data, input logic good);
        if (good) begin
            if (load_on) fifo_level = 0; // earlier bytes drained long before this frame
            if (fifo_level < FIFO_DEPTH) begin
                expected_bytes.push_back(data);
                if (!load_on) fifo_level++; // a running loader pops it within 3 cycles
            end else begin
                dropped++;
            end
        end
    endtask

    task automatic transmit(input logic [7:0] data, input logic good);
        send_frame(data, good);
        model_frame(data, good);
    endtask

    task automatic set_load(input logic on);
        @(posedge clk_in);
        load_en <= on;
        load_on = on;
    endtask

    task automatic wait_for_count(input int target, input string test);
        int cycles;
        cycles = 0;
        while (byte_count !== 32'(target) && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (byte_count !== 32'(target)) begin
            errors++;
            $display("%s: timed out waiting for byte_count to reach %0d, it stayed at %0d",
                     test, target, byte_count);
        end
        repeat (2) @(posedge clk_in);
    endtask

    // byte n belongs in word BASE_ADDR + n/4, lane n%4
    task automatic check_sram(input string test);
        logic [SRAM_AW-1:0] addr;
        int                 lane;
        for (int n = 0; n < expected_bytes.size(); n++) begin
            addr = BASE_ADDR + SRAM_AW'(n / 4);
            lane = n % 4;
            if (!sram_mem.exists(addr)) begin
                errors++;
                $display("%s: byte %0d was never written to word %0h", test, n, addr);
            end else begin
                check_value($sformatf("%s byte %0d", test, n), 32'(expected_bytes[n]),
                            32'(sram_mem[addr][lane*8 +: 8]));
            end
        end
        check_value({test, " write count"}, 32'(expected_bytes.size()), 32'(write_count));
    endtask

    initial begin
        logic [7:0] data;
        logic       good;
        int         paused_start;
        int         assert_fails;
        arst_n  = 1'b0;
        rxd     = 1'b1;
        load_en = 1'b0;
        repeat (2) @(posedge clk_in);
        arst_n <= 1'b1;
        @(posedge clk_in);

        check_value("reset we_n", 32'h1, 32'(sram.we_n));
        check_value("reset ce_n", 32'h1, 32'(sram.ce_n));
        check_value("reset be_n", 32'hf, 32'(sram.be_n));
        check_value("reset frame_err", 32'h0, 32'(frame_err));
        check_value("reset overflow", 32'h0, 32'(overflow));
        check_value("reset byte_count", 32'h0, byte_count);

        set_load(1'b1);
        repeat (40) begin
            data = 8'($random(seed));
            transmit(data, 1'b1);
        end
        wait_for_count(expected_bytes.size(), "random frames");
        check_sram("random frames");
        check_value("random frames frame_err", 32'h0, 32'(frame_err));
        check_value("random frames overflow", 32'h0, 32'(overflow));

        data = 8'($random(seed));
        transmit(data, 1'b0); // stop bit forced to 0
        check_value("bad stop frame_err", 32'h1, 32'(frame_err));
        repeat (8) begin
            data = 8'($random(seed));
            good = ($random(seed) & 3) != 0;
            transmit(data, good);
        end
        wait_for_count(expected_bytes.size(), "bad stop");
        check_sram("bad stop");

        set_load(1'b0);
        paused_start = expected_bytes.size();
        repeat (6) begin
            data = 8'($random(seed));
            transmit(data, 1'b1);
        end
        check_value("paused byte_count", 32'(paused_start), byte_count);
        check_value("paused overflow", 32'h1, 32'(overflow));
        set_load(1'b1);
        wait_for_count(expected_bytes.size(), "paused load");
        check_sram("paused load");
        check_value("paused bytes written", 32'(paused_start + FIFO_DEPTH), 32'(write_count));
        check_value("paused dropped", 32'h2, 32'(dropped));

        check_value("final byte_count", 32'(expected_bytes.size()), byte_count);

        assert_fails = uart_loader_top_inst.uart_loader_asserts_inst.fail_count;
        $display("errors: %0d of %0d checks, assertion failures: %0d",
                 errors, checks, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/uart_pkg.sv
verilog/sram_pkg.sv
verilog/uart_rx.sv
verilog/byte_fifo.sv
verilog/sram_loader.sv
verilog/uart_loader_top.sv
tests/uart_loader_asserts.sv
tests/tb_uart_loader.sv

// File: Bender.yml
package:
  name: uart_loader

sources:
  - files:
      - verilog/uart_pkg.sv
      - verilog/sram_pkg.sv
      - verilog/uart_rx.sv
      - verilog/byte_fifo.sv
      - verilog/sram_loader.sv
      - verilog/uart_loader_top.sv
  - target: test
    files:
      - tests/uart_loader_asserts.sv
      - tests/tb_uart_loader.sv
